// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int num_gprs = 32;
    localparam int gpr_id_bits = $clog2(num_gprs);
    localparam int operand_bits = 32;

    typedef logic [gpr_id_bits-1:0] t_gpr_id;

    typedef enum logic [1:0] {
        op_none = 2'd0,
        op_reg  = 2'd1,
        op_imm  = 2'd2
    } t_optype;

    // register view of the operand word, number in the low bits
    typedef struct packed {
        logic [operand_bits-gpr_id_bits-1:0] rsvd;
        t_gpr_id                             gpr;
    } t_reg_word;

    // same word read as register or immediate, chosen by optype
    typedef union packed {
        t_reg_word               reg_id;
        logic [operand_bits-1:0] imm;
    } t_operand_val;

    typedef struct packed {
        t_optype      optype;
        t_operand_val val;
    } t_operand;

    typedef struct packed {
        t_operand   dst;
        t_operand   src1;
        t_operand   src2;
        logic [7:0] simid;
    } t_uinstr;

endpackage

`default_nettype wire

// ==== source/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    localparam int num_pregs = 64;
    localparam int preg_id_bits = $clog2(num_pregs);

    // pregs not mapped at reset, handed out from first_free upward
    localparam int num_free = 32;
    localparam int first_free = num_pregs - num_free;
    localparam int free_ptr_bits = $clog2(num_free);

    localparam int prf_num_reads = 2;
    localparam int prf_num_writes = 2;

    typedef logic [preg_id_bits-1:0] t_preg_id;
    typedef logic [31:0] t_reg_data;
    typedef logic [free_ptr_bits-1:0] t_free_ptr;

    typedef struct packed {
        t_preg_id  pdst;
        t_reg_data data;
    } t_prf_wr_pkt;

    typedef struct packed {
        t_preg_id pdst;
        t_preg_id psrc1;
        logic     psrc1_pend;
        t_preg_id psrc2;
        logic     psrc2_pend;
        logic     alloc;
    } t_rename_pkt;

endpackage

`default_nettype wire

// ==== source/free_list.sv ====
`timescale 1ns/10ps
`default_nettype none

module free_list
    import rename_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  logic     alloc,
    output t_preg_id alloc_id,
    output logic     empty,

    input  logic     free_en,
    input  t_preg_id free_preg
);

t_preg_id                 ids_q [num_free-1:0];
t_free_ptr                head_q;
t_free_ptr                tail_q;
logic [free_ptr_bits:0]   count_q;
logic                     full;

// head entry is offered before the pop
assign alloc_id = ids_q[head_q];
assign empty = count_q == '0;
assign full = count_q == (free_ptr_bits + 1)'(num_free);

always_ff @(posedge clk) begin
    if (reset) begin
        head_q <= '0;
        tail_q <= '0;
        count_q <= (free_ptr_bits + 1)'(num_free);
        for (int i = 0; i < num_free; i++) begin
            ids_q[i] <= t_preg_id'(first_free + i);
        end
    end else begin
        if (alloc) begin
            head_q <= head_q + 1'b1;
        end
        if (free_en) begin
            ids_q[tail_q] <= free_preg;
            tail_q <= tail_q + 1'b1;
        end
        // pop and push together leave the count alone
        case ({alloc, free_en})
            2'b10:   count_q <= count_q - 1'b1;
            2'b01:   count_q <= count_q + 1'b1;
            default: count_q <= count_q;
        endcase
    end
end

a_no_alloc_empty: assert property (
    @(posedge clk) disable iff (reset)
    alloc |-> !empty
) else $error("free list popped while empty");

// a push into a full list is only legal alongside a pop
a_no_push_full: assert property (
    @(posedge clk) disable iff (reset)
    free_en |-> (!full || alloc)
) else $error("free list pushed while full");

endmodule

`default_nettype wire

// ==== source/map_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module map_table
    import rv_pkg::*, rename_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  t_operand src1,
    input  t_operand src2,
    output t_preg_id psrc1,
    output t_preg_id psrc2,
    output logic     psrc1_pend,
    output logic     psrc2_pend,

    input  logic     upd_en,
    input  t_gpr_id  upd_gpr,
    input  t_preg_id upd_preg,

    input  logic     wr_en   [prf_num_writes-1:0],
    input  t_preg_id wr_pdst [prf_num_writes-1:0]
);

t_preg_id             map_q [num_gprs-1:0];
logic [num_pregs-1:0] pend_q;
logic [num_pregs-1:0] pend_wr_clr;
logic [num_pregs-1:0] pend_byp;
logic [num_pregs-1:0] pend_set;

t_operand             src       [1:0];
t_preg_id             psrc      [1:0];
logic                 psrc_pend [1:0];

// writebacks this cycle
always_comb begin
    pend_wr_clr = '0;
    for (int w = 0; w < prf_num_writes; w++) begin
        if (wr_en[w]) begin
            pend_wr_clr[wr_pdst[w]] = 1'b1;
        end
    end
end

// lookups see the clear of a same-cycle write
assign pend_byp = pend_q & ~pend_wr_clr;
assign pend_set = {{(num_pregs - 1){1'b0}}, upd_en} << upd_preg;

assign src[0] = src1;
assign src[1] = src2;

always_comb begin
    for (int s = 0; s < 2; s++) begin
        psrc[s] = '0;
        psrc_pend[s] = 1'b0;
        // x0 and non-register operands stay at preg 0
        if (src[s].optype == op_reg && src[s].val.reg_id.gpr != '0) begin
            psrc[s] = map_q[src[s].val.reg_id.gpr];
            psrc_pend[s] = pend_byp[psrc[s]];
        end
    end
end

assign psrc1 = psrc[0];
assign psrc2 = psrc[1];
assign psrc1_pend = psrc_pend[0];
assign psrc2_pend = psrc_pend[1];

always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < num_gprs; i++) begin
            map_q[i] <= t_preg_id'(i);
        end
        pend_q <= '0;
    end else begin
        if (upd_en) begin
            map_q[upd_gpr] <= upd_preg;
        end
        pend_q <= pend_byp | pend_set;
    end
end

a_upd_not_x0: assert property (
    @(posedge clk) disable iff (reset)
    upd_en |-> upd_gpr != '0
) else $error("map update targets x0");

// a preg coming off the free list must have been written back
a_alloc_not_pend: assert property (
    @(posedge clk) disable iff (reset)
    upd_en |-> !pend_q[upd_preg]
) else $error("allocated preg still pending");

endmodule

`default_nettype wire

// ==== source/prf.sv ====
`timescale 1ns/10ps
`default_nettype none

module prf
    import rename_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        wr_en   [prf_num_writes-1:0],
    input  t_prf_wr_pkt wr_pkt  [prf_num_writes-1:0],

    input  logic        rd_en   [prf_num_reads-1:0],
    input  t_preg_id    rd_psrc [prf_num_reads-1:0],
    output t_reg_data   rd_data [prf_num_reads-1:0]
);

t_reg_data regs_q [num_pregs-1:0];
t_reg_data rd_byp [prf_num_reads-1:0];

always_ff @(posedge clk) begin
    for (int w = 0; w < prf_num_writes; w++) begin
        if (wr_en[w]) begin
            regs_q[wr_pkt[w].pdst] <= wr_pkt[w].data;
        end
    end
end

// write-first, entry 0 is hardwired to zero
always_comb begin
    for (int r = 0; r < prf_num_reads; r++) begin
        rd_byp[r] = regs_q[rd_psrc[r]];
        for (int w = 0; w < prf_num_writes; w++) begin
            if (wr_en[w] && wr_pkt[w].pdst == rd_psrc[r]) begin
                rd_byp[r] = wr_pkt[w].data;
            end
        end
        if (rd_psrc[r] == '0) begin
            rd_byp[r] = '0;
        end
    end
end

always_ff @(posedge clk) begin
    for (int r = 0; r < prf_num_reads; r++) begin
        if (reset) begin
            rd_data[r] <= '0;
        end else if (rd_en[r]) begin
            rd_data[r] <= rd_byp[r];
        end
    end
end

for (genvar a = 0; a < prf_num_writes; a++) begin : g_wr_a
    for (genvar b = a + 1; b < prf_num_writes; b++) begin : g_wr_b
        a_wr_unique: assert property (
            @(posedge clk) disable iff (reset)
            (wr_en[a] && wr_en[b]) |-> wr_pkt[a].pdst != wr_pkt[b].pdst
        ) else $error("two writebacks to one preg");
    end
end

endmodule

`default_nettype wire

// ==== source/rename.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename
    import rv_pkg::*, rename_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        valid_rn0,
    input  t_uinstr     uinstr_rn0,
    output logic        stall_rn0,

    input  logic        wr_en  [prf_num_writes-1:0],
    input  t_prf_wr_pkt wr_pkt [prf_num_writes-1:0],

    input  logic        free_en,
    input  t_preg_id    free_preg,

    output logic        valid_rn1,
    output t_uinstr     uinstr_rn1,
    output t_rename_pkt rename_rn1
);

t_gpr_id     dst_gpr;
logic        need_pdst;
logic        alloc;
logic        accept;
logic        fl_empty;
t_preg_id    alloc_id;
t_preg_id    psrc1;
t_preg_id    psrc2;
logic        psrc1_pend;
logic        psrc2_pend;
t_preg_id    wr_pdst [prf_num_writes-1:0];
t_rename_pkt rename_rn0;

assign dst_gpr = uinstr_rn0.dst.val.reg_id.gpr;
assign need_pdst = uinstr_rn0.dst.optype == op_reg && dst_gpr != '0;

assign stall_rn0 = valid_rn0 & need_pdst & fl_empty;
assign accept = valid_rn0 & ~stall_rn0;
assign alloc = accept & need_pdst;

always_comb begin
    for (int w = 0; w < prf_num_writes; w++) begin
        wr_pdst[w] = wr_pkt[w].pdst;
    end
end

free_list u_free_list (
    .clk       (clk),
    .reset     (reset),
    .alloc     (alloc),
    .alloc_id  (alloc_id),
    .empty     (fl_empty),
    .free_en   (free_en),
    .free_preg (free_preg)
);

// lookups use the map as it was before this instruction
map_table u_map_table (
    .clk        (clk),
    .reset      (reset),
    .src1       (uinstr_rn0.src1),
    .src2       (uinstr_rn0.src2),
    .psrc1      (psrc1),
    .psrc2      (psrc2),
    .psrc1_pend (psrc1_pend),
    .psrc2_pend (psrc2_pend),
    .upd_en     (alloc),
    .upd_gpr    (dst_gpr),
    .upd_preg   (alloc_id),
    .wr_en      (wr_en),
    .wr_pdst    (wr_pdst)
);

always_comb begin
    rename_rn0.pdst = alloc ? alloc_id : '0;
    rename_rn0.psrc1 = psrc1;
    rename_rn0.psrc1_pend = psrc1_pend;
    rename_rn0.psrc2 = psrc2;
    rename_rn0.psrc2_pend = psrc2_pend;
    rename_rn0.alloc = alloc;
end

always_ff @(posedge clk) begin
    if (reset) begin
        valid_rn1 <= 1'b0;
    end else begin
        valid_rn1 <= accept;
    end
end

// payload only moves on acceptance
always_ff @(posedge clk) begin
    if (accept) begin
        uinstr_rn1 <= uinstr_rn0;
        rename_rn1 <= rename_rn0;
    end
end

endmodule

`default_nettype wire

// ==== source/rename_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_top
    import rv_pkg::*, rename_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        valid_rn0,
    input  t_uinstr     uinstr_rn0,
    output logic        stall_rn0,

    input  logic        prf_wr_en   [prf_num_writes-1:0],
    input  t_prf_wr_pkt prf_wr_pkt  [prf_num_writes-1:0],

    input  logic        free_en,
    input  t_preg_id    free_preg,

    output logic        valid_rn1,
    output t_uinstr     uinstr_rn1,
    output t_rename_pkt rename_rn1,

    input  logic        prf_rd_en   [prf_num_reads-1:0],
    input  t_preg_id    prf_rd_psrc [prf_num_reads-1:0],
    output t_reg_data   prf_rd_data [prf_num_reads-1:0]
);

rename u_rename (
    .clk        (clk),
    .reset      (reset),
    .valid_rn0  (valid_rn0),
    .uinstr_rn0 (uinstr_rn0),
    .stall_rn0  (stall_rn0),
    .wr_en      (prf_wr_en),
    .wr_pkt     (prf_wr_pkt),
    .free_en    (free_en),
    .free_preg  (free_preg),
    .valid_rn1  (valid_rn1),
    .uinstr_rn1 (uinstr_rn1),
    .rename_rn1 (rename_rn1)
);

// writeback also clears pending bits inside rename
prf u_prf (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (prf_wr_en),
    .wr_pkt  (prf_wr_pkt),
    .rd_en   (prf_rd_en),
    .rd_psrc (prf_rd_psrc),
    .rd_data (prf_rd_data)
);

endmodule

`default_nettype wire

// ==== dv/tb_rename.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rename
    import rv_pkg::*, rename_pkg::*;
();

logic        clk;
logic        reset;
logic        valid_rn0;
t_uinstr     uinstr_rn0;
logic        stall_rn0;
logic        prf_wr_en   [prf_num_writes-1:0];
t_prf_wr_pkt prf_wr_pkt  [prf_num_writes-1:0];
logic        free_en;
t_preg_id    free_preg;
logic        valid_rn1;
t_uinstr     uinstr_rn1;
t_rename_pkt rename_rn1;
logic        prf_rd_en   [prf_num_reads-1:0];
t_preg_id    prf_rd_psrc [prf_num_reads-1:0];
t_reg_data   prf_rd_data [prf_num_reads-1:0];

// reference model of map, pending bits, free list and data
t_preg_id             map_m [num_gprs];
logic [num_pregs-1:0] pend_m;
logic [num_pregs-1:0] clr_m;
logic [num_pregs-1:0] written_m;
t_reg_data            data_m [num_pregs];
t_preg_id             fl_q [$];
t_preg_id             retire_q [$];
logic                 exp_valid;
t_uinstr              exp_ui;
t_rename_pkt          exp_rn;
logic                 exp_rd_chk [prf_num_reads];
t_reg_data            exp_rd [prf_num_reads];

// side inputs staged for the next driven cycle
logic                 nxt_wr_en [prf_num_writes];
t_prf_wr_pkt          nxt_wr_pkt [prf_num_writes];
logic                 nxt_rd_en [prf_num_reads];
t_preg_id             nxt_rd_psrc [prf_num_reads];
logic                 rel_en;
t_preg_id             rel_preg;

int seed;
int err_count;
int check_count;
int test_errs;

always #50 clk = ~clk;

rename_top UUT (
    .clk         (clk),
    .reset       (reset),
    .valid_rn0   (valid_rn0),
    .uinstr_rn0  (uinstr_rn0),
    .stall_rn0   (stall_rn0),
    .prf_wr_en   (prf_wr_en),
    .prf_wr_pkt  (prf_wr_pkt),
    .free_en     (free_en),
    .free_preg   (free_preg),
    .valid_rn1   (valid_rn1),
    .uinstr_rn1  (uinstr_rn1),
    .rename_rn1  (rename_rn1),
    .prf_rd_en   (prf_rd_en),
    .prf_rd_psrc (prf_rd_psrc),
    .prf_rd_data (prf_rd_data)
);

task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] want);
    check_count++;
    if (got !== want) begin
        $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, want);
        err_count++;
    end
endtask

task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("sim failed");
    $finish;
endtask

task automatic end_test(input string name);
    $display("%s: %0d errors", name, err_count - test_errs);
    test_errs = err_count;
endtask

function automatic t_operand reg_op(input int gpr);
    t_operand o;
    o = '0;
    o.optype = op_reg;
    o.val.reg_id.gpr = t_gpr_id'(gpr);
    return o;
endfunction

function automatic t_operand imm_op(input logic [31:0] value);
    t_operand o;
    o.optype = op_imm;
    o.val.imm = value;
    return o;
endfunction

function automatic t_uinstr make_instr(input t_operand d, input t_operand s1,
                                       input t_operand s2, input logic [7:0] id);
    t_uinstr u;
    u.dst = d;
    u.src1 = s1;
    u.src2 = s2;
    u.simid = id;
    return u;
endfunction

// x0 and non-register sources read preg 0
function automatic t_preg_id psrc_of(input t_operand s);
    if (s.optype == op_reg && s.val.reg_id.gpr != '0) begin
        return map_m[s.val.reg_id.gpr];
    end
    return '0;
endfunction

task automatic init_model();
    fl_q.delete();
    retire_q.delete();
    for (int i = 0; i < num_gprs; i++) begin
        map_m[i] = t_preg_id'(i);
    end
    for (int i = 0; i < num_free; i++) begin
        fl_q.push_back(t_preg_id'(first_free + i));
    end
    pend_m = '0;
    written_m = '0;
    exp_valid = 1'b0;
    for (int r = 0; r < prf_num_reads; r++) begin
        exp_rd_chk[r] = 1'b0;
    end
endtask

// runs at the falling edge to check the last edge and predict the next
task automatic model_cycle();
    t_uinstr     ui;
    t_rename_pkt rn;
    logic        need;
    logic        stall_e;
    t_gpr_id     gpr;
    check_val("valid_rn1", 128'(valid_rn1), 128'(exp_valid));
    if (exp_valid) begin
        check_val("uinstr_rn1", 128'(uinstr_rn1), 128'(exp_ui));
        check_val("rename_rn1", 128'(rename_rn1), 128'(exp_rn));
    end
    for (int r = 0; r < prf_num_reads; r++) begin
        if (exp_rd_chk[r]) begin
            check_val($sformatf("prf_rd_data[%0d]", r), 128'(prf_rd_data[r]), 128'(exp_rd[r]));
        end
    end
    ui = uinstr_rn0;
    gpr = ui.dst.val.reg_id.gpr;
    need = ui.dst.optype == op_reg && gpr != '0;
    stall_e = valid_rn0 && need && fl_q.size() == 0;
    check_val("stall_rn0", 128'(stall_rn0), 128'(stall_e));
    clr_m = '0;
    for (int w = 0; w < prf_num_writes; w++) begin
        if (prf_wr_en[w]) begin
            clr_m[prf_wr_pkt[w].pdst] = 1'b1;
            data_m[prf_wr_pkt[w].pdst] = prf_wr_pkt[w].data;
            written_m[prf_wr_pkt[w].pdst] = 1'b1;
        end
    end
    rn = '0;
    rn.psrc1 = psrc_of(ui.src1);
    rn.psrc1_pend = pend_m[rn.psrc1] & ~clr_m[rn.psrc1];
    rn.psrc2 = psrc_of(ui.src2);
    rn.psrc2_pend = pend_m[rn.psrc2] & ~clr_m[rn.psrc2];
    pend_m = pend_m & ~clr_m;
    exp_valid = valid_rn0 && !stall_e;
    if (exp_valid && need) begin
        rn.alloc = 1'b1;
        rn.pdst = fl_q.pop_front();
        retire_q.push_back(map_m[gpr]);
        map_m[gpr] = rn.pdst;
        pend_m[rn.pdst] = 1'b1;
    end
    if (exp_valid) begin
        exp_ui = ui;
        exp_rn = rn;
    end
    if (free_en) begin
        fl_q.push_back(free_preg);
    end
    for (int r = 0; r < prf_num_reads; r++) begin
        exp_rd_chk[r] = prf_rd_en[r] && (prf_rd_psrc[r] == '0 || written_m[prf_rd_psrc[r]]);
        exp_rd[r] = (prf_rd_psrc[r] == '0) ? '0 : data_m[prf_rd_psrc[r]];
    end
endtask

task automatic drive_cycle(input logic v, input t_uinstr ui);
    @(posedge clk);
    valid_rn0 <= v;
    uinstr_rn0 <= ui;
    free_en <= rel_en;
    free_preg <= rel_preg;
    for (int w = 0; w < prf_num_writes; w++) begin
        prf_wr_en[w] <= nxt_wr_en[w];
        prf_wr_pkt[w] <= nxt_wr_pkt[w];
        nxt_wr_en[w] = 1'b0;
    end
    for (int r = 0; r < prf_num_reads; r++) begin
        prf_rd_en[r] <= nxt_rd_en[r];
        prf_rd_psrc[r] <= nxt_rd_psrc[r];
        nxt_rd_en[r] = 1'b0;
    end
    rel_en = 1'b0;
    @(negedge clk);
    model_cycle();
endtask

task automatic idle_cycle();
    drive_cycle(1'b0, '0);
endtask

// holds the instruction until it is accepted
task automatic send_instr(input t_uinstr ui);
    int waits;
    waits = 0;
    drive_cycle(1'b1, ui);
    while (stall_rn0) begin
        waits++;
        if (waits > 64) begin
            abort_run("stall_rn0 stayed high while an instruction was held");
        end
        drive_cycle(1'b1, ui);
    end
endtask

// return the oldest displaced preg and write it back first if still pending
task automatic plan_release();
    t_preg_id p;
    if (retire_q.size() > 0) begin
        p = retire_q.pop_front();
        rel_en = 1'b1;
        rel_preg = p;
        if (pend_m[p] && !(nxt_wr_en[0] && nxt_wr_pkt[0].pdst == p)) begin
            nxt_wr_en[1] = 1'b1;
            nxt_wr_pkt[1] = '{pdst: p, data: $random(seed)};
        end
    end
endtask

task automatic reset_mapping();
    // valid was high at the last reset edge
    @(negedge clk);
    check_val("valid_rn1", 128'(valid_rn1), 128'(0));
    for (int g = 0; g < num_gprs; g++) begin
        send_instr(make_instr('0, reg_op(g), reg_op(num_gprs - 1 - g), 8'(g)));
        idle_cycle();
        check_val("rename_rn1.psrc1", 128'(rename_rn1.psrc1), 128'(g));
        check_val("rename_rn1.psrc2", 128'(rename_rn1.psrc2), 128'(num_gprs - 1 - g));
        check_val("rename_rn1 pend bits",
                  128'({rename_rn1.psrc1_pend, rename_rn1.psrc2_pend}), 128'(0));
    end
    end_test("reset_mapping");
endtask

task automatic allocation_order();
    for (int i = 0; i < 4; i++) begin
        send_instr(make_instr(reg_op(i + 1), reg_op(i + 1), '0, 8'(i)));
        idle_cycle();
        check_val("rename_rn1.pdst", 128'(rename_rn1.pdst), 128'(first_free + i));
        check_val("rename_rn1.psrc1", 128'(rename_rn1.psrc1), 128'(i + 1));
    end
    send_instr(make_instr('0, reg_op(1), reg_op(2), 8'h10));
    idle_cycle();
    check_val("rename_rn1.psrc1", 128'(rename_rn1.psrc1), 128'(first_free));
    check_val("rename_rn1.psrc2", 128'(rename_rn1.psrc2), 128'(first_free + 1));
    check_val("rename_rn1 pend bits",
              128'({rename_rn1.psrc1_pend, rename_rn1.psrc2_pend}), 128'(2'b11));
    end_test("allocation_order");
endtask

task automatic writeback_clears_pending();
    t_reg_data d;
    d = 32'h1234_5678;
    // write to x1's preg lands in the lookup cycle
    nxt_wr_en[0] = 1'b1;
    nxt_wr_pkt[0] = '{pdst: t_preg_id'(first_free), data: d};
    send_instr(make_instr('0, reg_op(1), reg_op(2), 8'h20));
    idle_cycle();
    check_val("rename_rn1.psrc1_pend", 128'(rename_rn1.psrc1_pend), 128'(0));
    check_val("rename_rn1.psrc2_pend", 128'(rename_rn1.psrc2_pend), 128'(1));
    nxt_wr_en[1] = 1'b1;
    nxt_wr_pkt[1] = '{pdst: t_preg_id'(first_free + 1), data: ~d};
    idle_cycle();
    send_instr(make_instr('0, reg_op(2), '0, 8'h21));
    idle_cycle();
    check_val("rename_rn1.psrc1_pend", 128'(rename_rn1.psrc1_pend), 128'(0));
    nxt_rd_en[0] = 1'b1;
    nxt_rd_psrc[0] = t_preg_id'(first_free);
    nxt_rd_en[1] = 1'b1;
    nxt_rd_psrc[1] = t_preg_id'(first_free + 2);
    nxt_wr_en[0] = 1'b1;
    nxt_wr_pkt[0] = '{pdst: t_preg_id'(first_free + 2), data: d ^ 32'hffff_0000};
    idle_cycle();
    idle_cycle();
    check_val("prf_rd_data[0]", 128'(prf_rd_data[0]), 128'(d));
    check_val("prf_rd_data[1]", 128'(prf_rd_data[1]), 128'(d ^ 32'hffff_0000));
    end_test("writeback_clears_pending");
endtask

task automatic exhaustion_stall();
    t_uinstr  ui;
    t_preg_id rel;
    int       k;
    k = 0;
    while (fl_q.size() > 0) begin
        send_instr(make_instr(reg_op(1 + k % 31), '0, '0, 8'(k)));
        k++;
    end
    ui = make_instr(reg_op(5), reg_op(6), '0, 8'h40);
    drive_cycle(1'b1, ui);
    check_val("stall_rn0", 128'(stall_rn0), 128'(1));
    rel = retire_q[0];
    plan_release();
    drive_cycle(1'b1, ui);
    check_val("stall_rn0", 128'(stall_rn0), 128'(1));
    check_val("valid_rn1", 128'(valid_rn1), 128'(0));
    send_instr(ui);
    idle_cycle();
    check_val("valid_rn1", 128'(valid_rn1), 128'(1));
    check_val("rename_rn1.pdst", 128'(rename_rn1.pdst), 128'(rel));
    end_test("exhaustion_stall");
endtask

task automatic immediates_and_x0();
    t_preg_id head;
    for (int i = 0; i < 4; i++) begin
        plan_release();
        idle_cycle();
    end
    send_instr(make_instr('0, reg_op(3), imm_op(32'hdead_beef), 8'h50));
    idle_cycle();
    check_val("rename_rn1.psrc2", 128'(rename_rn1.psrc2), 128'(0));
    check_val("rename_rn1.psrc2_pend", 128'(rename_rn1.psrc2_pend), 128'(0));
    check_val("uinstr_rn1.src2.imm", 128'(uinstr_rn1.src2.val.imm), 128'(32'hdead_beef));
    head = fl_q[0];
    send_instr(make_instr(reg_op(0), reg_op(3), '0, 8'h51));
    idle_cycle();
    check_val("rename_rn1.alloc", 128'(rename_rn1.alloc), 128'(0));
    send_instr(make_instr(reg_op(7), '0, '0, 8'h52));
    idle_cycle();
    check_val("rename_rn1.pdst", 128'(rename_rn1.pdst), 128'(head));
    end_test("immediates_and_x0");
endtask

function automatic t_operand rand_operand(input int kinds);
    int k;
    k = $unsigned($random(seed)) % kinds;
    if (k == 1) begin
        return reg_op($unsigned($random(seed)) % num_gprs);
    end
    if (k == 2) begin
        return imm_op($random(seed));
    end
    return '0;
endfunction

task automatic random_mix();
    t_uinstr ui;
    logic    v;
    logic    held;
    held = 1'b0;
    v = 1'b0;
    ui = '0;
    for (int i = 0; i < 400; i++) begin
        // a stalled instruction is held steady
        if (!held) begin
            v = ($unsigned($random(seed)) % 4) != 0;
            ui = make_instr(rand_operand(2), rand_operand(3), rand_operand(3), 8'(i));
        end
        if (1'($random(seed))) begin
            nxt_wr_en[0] = 1'b1;
            nxt_wr_pkt[0].pdst = t_preg_id'(1 + $unsigned($random(seed)) % (num_pregs - 1));
            nxt_wr_pkt[0].data = $random(seed);
        end
        if (($unsigned($random(seed)) % 4) == 0) begin
            plan_release();
        end
        for (int r = 0; r < prf_num_reads; r++) begin
            nxt_rd_en[r] = 1'($random(seed));
            nxt_rd_psrc[r] = t_preg_id'($random(seed));
        end
        drive_cycle(v, ui);
        held = stall_rn0;
    end
    idle_cycle();
    end_test("random_mix");
endtask

initial begin
    seed = 32'hc374;
    err_count = 0;
    check_count = 0;
    test_errs = 0;
    clk = 1'b0;
    reset = 1'b1;
    // valid stays high through reset
    valid_rn0 = 1'b1;
    uinstr_rn0 = '0;
    free_en = 1'b0;
    free_preg = '0;
    rel_en = 1'b0;
    rel_preg = '0;
    for (int w = 0; w < prf_num_writes; w++) begin
        prf_wr_en[w] = 1'b0;
        prf_wr_pkt[w] = '0;
        nxt_wr_en[w] = 1'b0;
        nxt_wr_pkt[w] = '0;
    end
    for (int r = 0; r < prf_num_reads; r++) begin
        prf_rd_en[r] = 1'b0;
        prf_rd_psrc[r] = '0;
        nxt_rd_en[r] = 1'b0;
        nxt_rd_psrc[r] = '0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    valid_rn0 <= 1'b0;
    init_model();
    reset_mapping();
    allocation_order();
    writeback_clears_pending();
    exhaustion_stall();
    immediates_and_x0();
    random_mix();
    $display("%0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
        $display("sim passed");
    end else begin
        $display("sim failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== tb.f ====
source/rv_pkg.sv
source/rename_pkg.sv
source/free_list.sv
source/map_table.sv
source/prf.sv
source/rename.sv
source/rename_top.sv
dv/tb_rename.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rename testbench with verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_rename --Mdir "$obj_dir" -o tb_rename -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj_dir/tb_rename" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if [ ! -s "$log" ]; then
    echo "simulation log is empty"
    exit 1
fi

if grep -q "sim failed" "$log"; then
    exit 1
fi
exit 0
